// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_jtag_debug
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	$(SIM) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
rtl/jtag_debug_pkg.sv
rtl/tap_controller.sv
rtl/jtag_data_path.sv
rtl/debug_reg_file.sv
rtl/event_counter.sv
rtl/jtag_debug_top.sv
verification/jtag_debug_checker.sv
verification/tb_jtag_debug.sv

// ==== rtl/debug_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_reg_file import jtag_debug_pkg::*; #(
	parameter int CFG_REGS    = 4,
	parameter int COUNT_WIDTH = 16
) (
	input  wire logic                   clk,
	input  wire logic                   rst_i,
	input  wire logic                   reg_update_i,
	input  wire logic                   reg_write_i,
	input  wire logic [ADDR_WIDTH-1:0]  reg_addr_i,
	input  wire logic [DATA_WIDTH-1:0]  reg_wdata_i,
	input  wire logic [COUNT_WIDTH-1:0] count_i,
	input  wire logic [DATA_WIDTH-1:0]  status_i,
	output logic [DATA_WIDTH-1:0]       rd_data_o,
	output cfg_word_t                   cfg_o [CFG_REGS],
	output logic                        count_clear_o
);
	logic [ADDR_WIDTH-1:0] rd_addr;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < CFG_REGS; i++) begin
				cfg_o[i] <= '0;
			end
			rd_addr <= '0;
			count_clear_o <= 1'b0;
		end else begin
			count_clear_o <= 1'b0;
			if (reg_update_i) begin
				rd_addr <= reg_addr_i;
				if (reg_write_i) begin
					for (int i = 0; i < CFG_REGS; i++) begin
						if (reg_addr_i == ADDR_WIDTH'(i)) begin
							cfg_o[i] <= reg_wdata_i;
						end
					end
					// Word 0 bit 1 is a clear command, never held
					if (reg_addr_i == '0) begin
						cfg_o[0][1] <= 1'b0;
						count_clear_o <= reg_wdata_i[1];
					end
				end
			end
		end
	end

	always_comb begin
		rd_data_o = '0;
		if (rd_addr == ADDR_COUNT) begin
			rd_data_o = DATA_WIDTH'(count_i);
		end else if (rd_addr == ADDR_STATUS) begin
			rd_data_o = status_i;
		end
		for (int i = 0; i < CFG_REGS; i++) begin
			if (rd_addr == ADDR_WIDTH'(i)) begin
				rd_data_o = cfg_o[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/event_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module event_counter #(
	parameter int COUNT_WIDTH = 16
) (
	input  wire logic          clk,
	input  wire logic          rst_i,
	input  wire logic          enable_i,
	input  wire logic          clear_i,
	input  wire logic          event_i,
	output logic [COUNT_WIDTH-1:0] count_o
);
	logic saturated;

	assign saturated = &count_o;

	// Clear wins over a same-cycle event
	always_ff @(posedge clk) begin
		if (rst_i) begin
			count_o <= '0;
		end else if (clear_i) begin
			count_o <= '0;
		end else if (enable_i && event_i && !saturated) begin
			count_o <= count_o + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/jtag_data_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_data_path import jtag_debug_pkg::*; #(
	parameter logic [31:0] IDCODE_VALUE = 32'h1a5c_e0b3
) (
	input  wire logic                  clk,
	input  wire logic                  rst_i,
	input  wire logic                  tdi_i,
	input  wire logic                  tck_fall_i,
	input  wire logic                  test_reset_i,
	input  wire logic                  capture_dr_i,
	input  wire logic                  shift_dr_i,
	input  wire logic                  update_dr_i,
	input  wire logic                  capture_ir_i,
	input  wire logic                  shift_ir_i,
	input  wire logic                  update_ir_i,
	input  wire logic [DATA_WIDTH-1:0] rd_data_i,
	output logic                       tdo_o,
	output logic                       reg_update_o,
	output logic                       reg_write_o,
	output logic [ADDR_WIDTH-1:0]      reg_addr_o,
	output logic [DATA_WIDTH-1:0]      reg_wdata_o
);
	logic [IR_WIDTH-1:0]     ir_shift;
	logic [IR_WIDTH-1:0]     ir_hold;
	logic                    ir_scan;
	logic [31:0]             idcode_sr;
	logic                    bypass_sr;
	logic [ACCESS_WIDTH-1:0] access_sr;
	logic                    sel_idcode;
	logic                    sel_access;
	logic                    dr_bit;

	assign sel_idcode = (ir_hold == INSTR_IDCODE);
	assign sel_access = (ir_hold == INSTR_REG_ACCESS);

	// Unlisted codes fall through to BYPASS
	always_comb begin
		case (ir_hold)
			INSTR_IDCODE:     dr_bit = idcode_sr[0];
			INSTR_REG_ACCESS: dr_bit = access_sr[0];
			default:          dr_bit = bypass_sr;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ir_hold <= INSTR_IDCODE;
			ir_scan <= 1'b0;
			reg_update_o <= 1'b0;
			reg_addr_o <= '0;
			tdo_o <= 1'b0;
		end else begin
			reg_update_o <= 1'b0;
			if (test_reset_i) begin
				ir_hold <= INSTR_IDCODE;
				ir_scan <= 1'b0;
			end else if (update_ir_i) begin
				ir_hold <= ir_shift;
				ir_scan <= 1'b0;
			end else if (capture_ir_i) begin
				ir_scan <= 1'b1;
			end
			if (update_dr_i && sel_access) begin
				reg_update_o <= 1'b1;
				reg_addr_o <= access_sr[DATA_WIDTH +: ADDR_WIDTH];
			end
			if (tck_fall_i) begin
				tdo_o <= ir_scan ? ir_shift[0] : dr_bit;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture_ir_i) begin
			ir_shift <= IR_WIDTH'(1);
		end else if (shift_ir_i) begin
			ir_shift <= {tdi_i, ir_shift[IR_WIDTH-1:1]};
		end

		// Read-back word carries the last address with the write flag clear
		if (capture_dr_i) begin
			idcode_sr <= IDCODE_VALUE;
			bypass_sr <= 1'b0;
			access_sr <= {1'b0, reg_addr_o, rd_data_i};
		end else if (shift_dr_i) begin
			if (sel_idcode) begin
				idcode_sr <= {tdi_i, idcode_sr[31:1]};
			end else if (sel_access) begin
				access_sr <= {tdi_i, access_sr[ACCESS_WIDTH-1:1]};
			end else begin
				bypass_sr <= tdi_i;
			end
		end

		if (update_dr_i && sel_access) begin
			reg_write_o <= access_sr[ACCESS_WIDTH-1];
			reg_wdata_o <= access_sr[DATA_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/jtag_debug_pkg.sv ====
`default_nettype none

package jtag_debug_pkg;

	// Instruction register
	localparam int IR_WIDTH = 4;
	localparam logic [IR_WIDTH-1:0] INSTR_IDCODE     = 4'd1;
	localparam logic [IR_WIDTH-1:0] INSTR_REG_ACCESS = 4'd8;
	localparam logic [IR_WIDTH-1:0] INSTR_BYPASS     = 4'd15;

	// Access word, from TDO end: data, address, write flag
	localparam int ADDR_WIDTH   = 6;
	localparam int DATA_WIDTH   = 32;
	localparam int ACCESS_WIDTH = 1 + ADDR_WIDTH + DATA_WIDTH;

	// Status addresses above the configuration words
	localparam logic [ADDR_WIDTH-1:0] ADDR_COUNT  = 6'd8;
	localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS = 6'd9;

	typedef enum logic [3:0] {
		TEST_LOGIC_RESET,
		RUN_TEST_IDLE,
		SELECT_DR_SCAN,
		CAPTURE_DR,
		SHIFT_DR,
		EXIT1_DR,
		PAUSE_DR,
		EXIT2_DR,
		UPDATE_DR,
		SELECT_IR_SCAN,
		CAPTURE_IR,
		SHIFT_IR,
		EXIT1_IR,
		PAUSE_IR,
		EXIT2_IR,
		UPDATE_IR
	} tap_state_t;

	typedef logic [DATA_WIDTH-1:0] cfg_word_t;

endpackage

`default_nettype wire

// ==== rtl/jtag_debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_debug_top import jtag_debug_pkg::*; #(
	parameter int          CFG_REGS     = 4,
	parameter int          COUNT_WIDTH  = 16,
	parameter logic [31:0] IDCODE_VALUE = 32'h1a5c_e0b3
) (
	input  wire logic                  clk,
	input  wire logic                  rst_i,
	input  wire logic                  tck_i,
	input  wire logic                  tms_i,
	input  wire logic                  tdi_i,
	input  wire logic                  trst_n_i,
	input  wire logic                  event_i,
	input  wire logic [DATA_WIDTH-1:0] status_i,
	output logic                       tdo_o,
	output cfg_word_t                  cfg_o [CFG_REGS]
);
	logic                   tdi_sync;
	logic                   tck_fall;
	logic                   test_reset;
	logic                   capture_dr;
	logic                   shift_dr;
	logic                   update_dr;
	logic                   capture_ir;
	logic                   shift_ir;
	logic                   update_ir;
	logic                   reg_update;
	logic                   reg_write;
	logic [ADDR_WIDTH-1:0]  reg_addr;
	logic [DATA_WIDTH-1:0]  reg_wdata;
	logic [DATA_WIDTH-1:0]  rd_data;
	logic                   count_clear;
	logic [COUNT_WIDTH-1:0] count;

	tap_controller u_tap (
		.clk          (clk),
		.rst_i        (rst_i),
		.tck_i        (tck_i),
		.tms_i        (tms_i),
		.tdi_i        (tdi_i),
		.trst_n_i     (trst_n_i),
		.tdi_o        (tdi_sync),
		.tck_fall_o   (tck_fall),
		.test_reset_o (test_reset),
		.capture_dr_o (capture_dr),
		.shift_dr_o   (shift_dr),
		.update_dr_o  (update_dr),
		.capture_ir_o (capture_ir),
		.shift_ir_o   (shift_ir),
		.update_ir_o  (update_ir)
	);

	jtag_data_path #(
		.IDCODE_VALUE (IDCODE_VALUE)
	) u_data_path (
		.clk          (clk),
		.rst_i        (rst_i),
		.tdi_i        (tdi_sync),
		.tck_fall_i   (tck_fall),
		.test_reset_i (test_reset),
		.capture_dr_i (capture_dr),
		.shift_dr_i   (shift_dr),
		.update_dr_i  (update_dr),
		.capture_ir_i (capture_ir),
		.shift_ir_i   (shift_ir),
		.update_ir_i  (update_ir),
		.rd_data_i    (rd_data),
		.tdo_o        (tdo_o),
		.reg_update_o (reg_update),
		.reg_write_o  (reg_write),
		.reg_addr_o   (reg_addr),
		.reg_wdata_o  (reg_wdata)
	);

	debug_reg_file #(
		.CFG_REGS    (CFG_REGS),
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_reg_file (
		.clk           (clk),
		.rst_i         (rst_i),
		.reg_update_i  (reg_update),
		.reg_write_i   (reg_write),
		.reg_addr_i    (reg_addr),
		.reg_wdata_i   (reg_wdata),
		.count_i       (count),
		.status_i      (status_i),
		.rd_data_o     (rd_data),
		.cfg_o         (cfg_o),
		.count_clear_o (count_clear)
	);

	// Counter enable is word 0 bit 0
	event_counter #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_counter (
		.clk      (clk),
		.rst_i    (rst_i),
		.enable_i (cfg_o[0][0]),
		.clear_i  (count_clear),
		.event_i  (event_i),
		.count_o  (count)
	);

endmodule

`default_nettype wire

// ==== rtl/tap_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tap_controller import jtag_debug_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_i,
	input  wire logic tck_i,
	input  wire logic tms_i,
	input  wire logic tdi_i,
	input  wire logic trst_n_i,
	output logic      tdi_o,
	output logic      tck_fall_o,
	output logic      test_reset_o,
	output logic      capture_dr_o,
	output logic      shift_dr_o,
	output logic      update_dr_o,
	output logic      capture_ir_o,
	output logic      shift_ir_o,
	output logic      update_ir_o
);
	logic [1:0] tck_sync;
	logic [1:0] tms_sync;
	logic [1:0] tdi_sync;
	logic [1:0] trst_n_sync;
	logic       tck_prev;
	logic       tck_rise;
	logic       tck_fall;
	tap_state_t state;
	tap_state_t state_next;

	// Pins are plain data on clk
	always_ff @(posedge clk) begin
		if (rst_i) begin
			tck_sync <= '0;
			tms_sync <= '1;
			tdi_sync <= '0;
			trst_n_sync <= '0;
			tck_prev <= 1'b0;
			tck_fall_o <= 1'b0;
		end else begin
			tck_sync <= {tck_sync[0], tck_i};
			tms_sync <= {tms_sync[0], tms_i};
			tdi_sync <= {tdi_sync[0], tdi_i};
			trst_n_sync <= {trst_n_sync[0], trst_n_i};
			tck_prev <= tck_sync[1];
			tck_fall_o <= tck_fall;
		end
	end

	// Keeps TDI in step with the registered strobes
	always_ff @(posedge clk) begin
		tdi_o <= tdi_sync[1];
	end

	assign tck_rise = tck_sync[1] & ~tck_prev;
	assign tck_fall = ~tck_sync[1] & tck_prev;

	always_comb begin
		state_next = state;
		case (state)
			TEST_LOGIC_RESET: state_next = tms_sync[1] ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
			RUN_TEST_IDLE:    state_next = tms_sync[1] ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_DR_SCAN:   state_next = tms_sync[1] ? SELECT_IR_SCAN : CAPTURE_DR;
			CAPTURE_DR:       state_next = tms_sync[1] ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR:         state_next = tms_sync[1] ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR:         state_next = tms_sync[1] ? UPDATE_DR : PAUSE_DR;
			PAUSE_DR:         state_next = tms_sync[1] ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR:         state_next = tms_sync[1] ? UPDATE_DR : SHIFT_DR;
			UPDATE_DR:        state_next = tms_sync[1] ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			SELECT_IR_SCAN:   state_next = tms_sync[1] ? TEST_LOGIC_RESET : CAPTURE_IR;
			CAPTURE_IR:       state_next = tms_sync[1] ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR:         state_next = tms_sync[1] ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR:         state_next = tms_sync[1] ? UPDATE_IR : PAUSE_IR;
			PAUSE_IR:         state_next = tms_sync[1] ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR:         state_next = tms_sync[1] ? UPDATE_IR : SHIFT_IR;
			UPDATE_IR:        state_next = tms_sync[1] ? SELECT_DR_SCAN : RUN_TEST_IDLE;
			default:          state_next = TEST_LOGIC_RESET;
		endcase
	end

	// Strobe named after the state being left on a TCK rise
	always_ff @(posedge clk) begin
		if (rst_i || !trst_n_sync[1]) begin
			state <= TEST_LOGIC_RESET;
			capture_dr_o <= 1'b0;
			shift_dr_o <= 1'b0;
			update_dr_o <= 1'b0;
			capture_ir_o <= 1'b0;
			shift_ir_o <= 1'b0;
			update_ir_o <= 1'b0;
		end else begin
			capture_dr_o <= tck_rise && (state == CAPTURE_DR);
			shift_dr_o <= tck_rise && (state == SHIFT_DR);
			update_dr_o <= tck_rise && (state == UPDATE_DR);
			capture_ir_o <= tck_rise && (state == CAPTURE_IR);
			shift_ir_o <= tck_rise && (state == SHIFT_IR);
			update_ir_o <= tck_rise && (state == UPDATE_IR);
			if (tck_rise) begin
				state <= state_next;
			end
		end
	end

	assign test_reset_o = (state == TEST_LOGIC_RESET);

endmodule

`default_nettype wire

// ==== verification/jtag_debug_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_debug_checker import jtag_debug_pkg::*; #(
	parameter int CFG_REGS = 4
) (
	input wire logic      clk,
	input wire logic      rst_i,
	input wire logic      capture_dr_i,
	input wire logic      shift_dr_i,
	input wire logic      update_dr_i,
	input wire logic      capture_ir_i,
	input wire logic      shift_ir_i,
	input wire logic      update_ir_i,
	input wire logic      reg_update_i,
	input wire logic      count_clear_i,
	input wire cfg_word_t cfg_i [CFG_REGS]
);
	logic [CFG_REGS*DATA_WIDTH-1:0] cfg_flat;
	int strobe_fails = 0;
	int cfg_fails = 0;
	int clear_fails = 0;

	always_comb begin
		for (int i = 0; i < CFG_REGS; i++) begin
			cfg_flat[i*DATA_WIDTH +: DATA_WIDTH] = cfg_i[i];
		end
	end

	// One TAP strobe per TCK rise at most
	strobe_onehot: assert property (@(posedge clk) disable iff (rst_i)
		$onehot0({capture_dr_i, shift_dr_i, update_dr_i, capture_ir_i, shift_ir_i, update_ir_i}))
	else begin
		$error("more than one TAP strobe high in the same cycle");
		strobe_fails++;
	end

	cfg_after_update: assert property (@(posedge clk) disable iff (rst_i)
		$changed(cfg_flat) |-> $past(reg_update_i))
	else begin
		$error("configuration output changed without a preceding register update");
		cfg_fails++;
	end

	clear_single: assert property (@(posedge clk) disable iff (rst_i)
		count_clear_i |=> !count_clear_i)
	else begin
		$error("counter clear held high for two cycles");
		clear_fails++;
	end

endmodule

bind jtag_debug_top jtag_debug_checker #(
	.CFG_REGS (CFG_REGS)
) u_checker (
	.clk           (clk),
	.rst_i         (rst_i),
	.capture_dr_i  (capture_dr),
	.shift_dr_i    (shift_dr),
	.update_dr_i   (update_dr),
	.capture_ir_i  (capture_ir),
	.shift_ir_i    (shift_ir),
	.update_ir_i   (update_ir),
	.reg_update_i  (reg_update),
	.count_clear_i (count_clear),
	.cfg_i         (cfg_o)
);

`default_nettype wire

// ==== verification/tb_jtag_debug.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_jtag_debug
	import jtag_debug_pkg::*;
();
	localparam int          CFG_REGS     = 4;
	localparam int          COUNT_WIDTH  = 16;
	localparam logic [31:0] IDCODE_VALUE = 32'h4b7a_1d03;
	localparam int          TCK_HALF     = 6;
	localparam int          RESET_CYCLES = 10;
	localparam int          EVENT_PULSES = 7;
	localparam int          ACCESS_TCKS  = ACCESS_WIDTH + 5;
	// TAP reset, idle entry, IDCODE scans, IR scans, bypass scan, then access scans
	localparam int TOTAL_TCKS = 6 + 1 + 2 * 37 + 2 * 10 + 21 + (3 * CFG_REGS + 12) * ACCESS_TCKS;
	localparam int TIMEOUT_CYCLES = TOTAL_TCKS * 2 * TCK_HALF + 2000;

	logic                  clk;
	logic                  rst_i;
	logic                  tck_i;
	logic                  tms_i;
	logic                  tdi_i;
	logic                  trst_n_i;
	logic                  event_i;
	logic [DATA_WIDTH-1:0] status_i;
	logic                  tdo_o;
	cfg_word_t             cfg_o [CFG_REGS];

	cfg_word_t model [CFG_REGS];
	integer    seed;
	int        errors;
	int        checks;
	int        tests;
	int        test_errors;

	jtag_debug_top #(
		.CFG_REGS     (CFG_REGS),
		.COUNT_WIDTH  (COUNT_WIDTH),
		.IDCODE_VALUE (IDCODE_VALUE)
	) u_dut (
		.clk      (clk),
		.rst_i    (rst_i),
		.tck_i    (tck_i),
		.tms_i    (tms_i),
		.tdi_i    (tdi_i),
		.trst_n_i (trst_n_i),
		.event_i  (event_i),
		.status_i (status_i),
		.tdo_o    (tdo_o),
		.cfg_o    (cfg_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Inputs change 1 ns after the rising edge
	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic expect_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual == expected) else begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %-16s %s", name, (errors == test_errors) ? "ok" : "FAILED");
		test_errors = errors;
	endtask

	// TDO is sampled at the end of the low phase, just before the rise
	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
		tck_i = 1'b0;
		tms_i = tms;
		tdi_i = tdi;
		wait_clocks(TCK_HALF);
		tdo = tdo_o;
		tck_i = 1'b1;
		wait_clocks(TCK_HALF);
	endtask

	task automatic tap_reset();
		logic bit_out;
		for (int i = 0; i < 5; i++) begin
			tck_cycle(1'b1, 1'b0, bit_out);
		end
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	task automatic scan_ir(input logic [IR_WIDTH-1:0] instr,
			output logic [IR_WIDTH-1:0] captured);
		logic bit_out;
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		for (int i = 0; i < IR_WIDTH; i++) begin
			tck_cycle(i == IR_WIDTH - 1, instr[i], bit_out);
			captured[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	// From Run-Test/Idle through capture, shift and update back to idle
	task automatic scan_dr(input logic [63:0] din, input int len, output logic [63:0] dout);
		logic bit_out;
		dout = '0;
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		logic [63:0] dout;
		scan_dr(64'({1'b1, addr, data}), ACCESS_WIDTH, dout);
		wait_clocks(4);
	endtask

	// First scan latches the address, second one captures its data
	task automatic read_reg(input logic [ADDR_WIDTH-1:0] addr, output logic [31:0] data);
		logic [63:0] dout;
		scan_dr(64'({1'b0, addr, 32'h0}), ACCESS_WIDTH, dout);
		scan_dr(64'({1'b0, addr, 32'h0}), ACCESS_WIDTH, dout);
		data = dout[31:0];
	endtask

	initial begin
		wait_clocks(TIMEOUT_CYCLES);
		$display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$finish;
	end

	initial begin
		logic [63:0]         dout;
		logic [IR_WIDTH-1:0] ir_out;
		logic [31:0]         data;
		logic [15:0]         pattern;
		logic                bit_out;
		int                  checker_fails;
		seed = 32'ha28b;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors = 0;
		rst_i = 1'b1;
		tck_i = 1'b0;
		tms_i = 1'b1;
		tdi_i = 1'b0;
		trst_n_i = 1'b1;
		event_i = 1'b0;
		status_i = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_i = 1'b0;
		wait_clocks(4);

		tap_reset();
		scan_dr(64'h0, 32, dout);
		expect_equal("idcode_reset", IDCODE_VALUE, dout[31:0]);
		finish_test("idcode_reset");

		scan_ir(INSTR_BYPASS, ir_out);
		expect_equal("bypass ir capture", 32'h1, 32'(ir_out));
		pattern = 16'($random(seed));
		scan_dr(64'(pattern), 16, dout);
		expect_equal("bypass delay", 32'({pattern[14:0], 1'b0}), dout[31:0]);
		finish_test("bypass");

		scan_ir(INSTR_REG_ACCESS, ir_out);
		for (int i = 0; i < CFG_REGS; i++) begin
			data = $random(seed);
			model[i] = (i == 0) ? (data & ~32'h2) : data;
			write_reg(ADDR_WIDTH'(i), data);
			expect_equal($sformatf("cfg_write cfg_o[%0d]", i), model[i], cfg_o[i]);
		end
		for (int i = 0; i < CFG_REGS; i++) begin
			read_reg(ADDR_WIDTH'(i), data);
			expect_equal($sformatf("cfg_read word %0d", i), model[i], data);
		end
		finish_test("cfg_write_read");

		write_reg('0, 32'h1);
		model[0] = 32'h1;
		for (int k = 0; k < EVENT_PULSES; k++) begin
			event_i = 1'b1;
			wait_clocks(1);
			event_i = 1'b0;
			wait_clocks(1);
		end
		read_reg(ADDR_COUNT, data);
		expect_equal("event_count pulses", EVENT_PULSES, data);
		write_reg('0, 32'h3);
		read_reg(ADDR_COUNT, data);
		expect_equal("event_count cleared", 32'h0, data);
		read_reg('0, data);
		expect_equal("event_count word 0", 32'h1, data);
		finish_test("event_count");

		status_i = $random(seed);
		read_reg(ADDR_STATUS, data);
		expect_equal("status_read", status_i, data);
		read_reg(6'h3f, data);
		expect_equal("status_read unused", 32'h0, data);
		finish_test("status_read");

		trst_n_i = 1'b0;
		wait_clocks(10);
		trst_n_i = 1'b1;
		wait_clocks(4);
		// Only TRST_n brought the TAP to Test-Logic-Reset, one TMS low clock leaves it
		tck_cycle(1'b0, 1'b0, bit_out);
		scan_dr(64'h0, 32, dout);
		expect_equal("trst idcode", IDCODE_VALUE, dout[31:0]);
		for (int i = 0; i < CFG_REGS; i++) begin
			expect_equal($sformatf("trst cfg_o[%0d]", i), model[i], cfg_o[i]);
		end
		finish_test("trst");

		checker_fails = u_dut.u_checker.strobe_fails + u_dut.u_checker.cfg_fails
			+ u_dut.u_checker.clear_fails;
		if (checker_fails != 0) begin
			$display("bound checker reported %0d assertion failures", checker_fails);
		end
		errors += checker_fails;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
